//--- Makefile
# Verilator build and run of the TCP connection engine testbench

VERILATOR ?= verilator
TOP       ?= tb_tcp_conn_engine
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal
PASS_MSG  := Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "test failed, see $(LOG)"; exit 1; }
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hdl/tcp_conn_engine.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_conn_engine #(
  parameter int                    CONNECTION_TIMEOUT  = 10000,
  parameter int                    DEFAULT_WINDOW_SIZE = 4000,
  parameter tcp_hdr_pkg::tcp_num_t ISN                 = 32'd2000
) (
  input  logic                       clk,
  input  logic                       rst,
  // user control
  input  logic                       connect,
  input  logic                       listen,
  input  tcp_hdr_pkg::tcp_port_t     loc_port,
  input  tcp_hdr_pkg::tcp_port_t     rem_port,
  input  tcp_hdr_pkg::ipv4_addr_t    rem_ip,
  // received header summary
  input  logic                       rx_val,
  input  tcp_hdr_pkg::ipv4_addr_t    rx_src_ip,
  input  tcp_hdr_pkg::tcp_port_t     rx_src_port,
  input  tcp_hdr_pkg::tcp_port_t     rx_dst_port,
  input  tcp_hdr_pkg::tcp_flags_t    rx_flags,
  input  tcp_hdr_pkg::tcp_num_t      rx_seq,
  input  tcp_hdr_pkg::tcp_num_t      rx_ack,
  // transmit header
  input  logic                       tx_acc,
  input  logic                       tx_done,
  output logic                       tx_rdy,
  output tcp_conn_pkg::seg_op_t      tx_op,
  output tcp_hdr_pkg::tcp_flags_t    tx_flags,
  output tcp_hdr_pkg::ipv4_addr_t    tx_dst_ip,
  output tcp_hdr_pkg::tcp_port_t     tx_src_port,
  output tcp_hdr_pkg::tcp_port_t     tx_dst_port,
  output tcp_hdr_pkg::tcp_num_t      tx_seq,
  output tcp_hdr_pkg::tcp_num_t      tx_ack,
  output tcp_hdr_pkg::tcp_wnd_t      tx_wnd,
  // connection status
  output tcp_conn_pkg::conn_status_t status,
  output tcp_hdr_pkg::ipv4_addr_t    con_ip,
  output tcp_hdr_pkg::tcp_port_t     con_port
);

  tcp_hdr_pkg::tcp_port_t con_loc_port;  // ports of the current connection
  tcp_hdr_pkg::tcp_port_t con_rem_port;
  logic                   tmr_en;
  logic                   timeout;

  tcp_seg_ifc seg_if ();

  tcp_seg_classifier classifier_i (
    .clk          (clk),
    .rst          (rst),
    .rx_val       (rx_val),
    .rx_src_ip    (rx_src_ip),
    .rx_src_port  (rx_src_port),
    .rx_dst_port  (rx_dst_port),
    .rx_flags     (rx_flags),
    .rx_seq       (rx_seq),
    .rx_ack       (rx_ack),
    .loc_port     (loc_port),
    .con_loc_port (con_loc_port),
    .con_rem_port (con_rem_port),
    .seg          (seg_if.classifier)
  );

  tcp_conn_timer #(
    .CONNECTION_TIMEOUT (CONNECTION_TIMEOUT)
  ) timer_i (
    .clk     (clk),
    .rst     (rst),
    .en      (tmr_en),
    .timeout (timeout)
  );

  tcp_conn_fsm #(
    .DEFAULT_WINDOW_SIZE (DEFAULT_WINDOW_SIZE),
    .ISN                 (ISN)
  ) fsm_i (
    .clk          (clk),
    .rst          (rst),
    .connect      (connect),
    .listen       (listen),
    .loc_port     (loc_port),
    .rem_port     (rem_port),
    .rem_ip       (rem_ip),
    .seg          (seg_if.fsm),
    .timeout      (timeout),
    .tmr_en       (tmr_en),
    .con_loc_port (con_loc_port),
    .con_rem_port (con_rem_port),
    .tx_acc       (tx_acc),
    .tx_done      (tx_done),
    .tx_rdy       (tx_rdy),
    .tx_op        (tx_op),
    .tx_flags     (tx_flags),
    .tx_dst_ip    (tx_dst_ip),
    .tx_src_port  (tx_src_port),
    .tx_dst_port  (tx_dst_port),
    .tx_seq       (tx_seq),
    .tx_ack       (tx_ack),
    .tx_wnd       (tx_wnd),
    .status       (status),
    .con_ip       (con_ip),
    .con_port     (con_port)
  );

endmodule : tcp_conn_engine

`default_nettype wire

//--- hdl/tcp_conn_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_conn_fsm #(
  parameter int                    DEFAULT_WINDOW_SIZE = 4000,
  parameter tcp_hdr_pkg::tcp_num_t ISN                 = 32'd2000
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       connect,
  input  logic                       listen,
  input  tcp_hdr_pkg::tcp_port_t     loc_port,
  input  tcp_hdr_pkg::tcp_port_t     rem_port,
  input  tcp_hdr_pkg::ipv4_addr_t    rem_ip,
  tcp_seg_ifc.fsm                    seg,
  input  logic                       timeout,
  output logic                       tmr_en,
  output tcp_hdr_pkg::tcp_port_t     con_loc_port,
  output tcp_hdr_pkg::tcp_port_t     con_rem_port,
  input  logic                       tx_acc,
  input  logic                       tx_done,
  output logic                       tx_rdy,
  output tcp_conn_pkg::seg_op_t      tx_op,
  output tcp_hdr_pkg::tcp_flags_t    tx_flags,
  output tcp_hdr_pkg::ipv4_addr_t    tx_dst_ip,
  output tcp_hdr_pkg::tcp_port_t     tx_src_port,
  output tcp_hdr_pkg::tcp_port_t     tx_dst_port,
  output tcp_hdr_pkg::tcp_num_t      tx_seq,
  output tcp_hdr_pkg::tcp_num_t      tx_ack,
  output tcp_hdr_pkg::tcp_wnd_t      tx_wnd,
  output tcp_conn_pkg::conn_status_t status,
  output tcp_hdr_pkg::ipv4_addr_t    con_ip,
  output tcp_hdr_pkg::tcp_port_t     con_port
);

  tcp_conn_pkg::conn_state_t  state;
  tcp_conn_pkg::close_t       close;
  tcp_conn_pkg::seg_op_t      hdr_op;    // segment for the current send state
  tcp_conn_pkg::conn_status_t hdr_sts;
  tcp_hdr_pkg::tcp_num_t      hdr_ack;
  tcp_hdr_pkg::tcp_num_t      loc_seq;   // control block
  tcp_hdr_pkg::tcp_num_t      loc_ack;
  tcp_hdr_pkg::ipv4_addr_t    rem_ip_q;
  logic                       is_send;
  logic                       is_server;
  logic                       fin_acked; // peer acked our fin
  logic                       usr_dcn;
  logic                       tx_take;

  assign usr_dcn     = is_server ? !listen : !connect;
  assign tx_take     = tx_rdy && tx_acc;
  assign tx_dst_ip   = rem_ip_q;
  assign tx_src_port = con_loc_port;
  assign tx_dst_port = con_rem_port;
  assign tx_wnd      = tcp_hdr_pkg::tcp_wnd_t'(DEFAULT_WINDOW_SIZE);

  //////////////////////////////////////////////////
  // header selection
  //////////////////////////////////////////////////
  always_comb begin
    is_send = 1'b1;
    hdr_op  = tcp_conn_pkg::op_ack;
    hdr_ack = loc_ack;
    hdr_sts = tcp_conn_pkg::tcp_disconnecting;
    case (state)
      tcp_conn_pkg::send_syn_s: begin
        hdr_op  = tcp_conn_pkg::op_syn;
        hdr_sts = tcp_conn_pkg::tcp_connecting;
      end
      tcp_conn_pkg::send_syn_ack_s: begin
        hdr_op  = tcp_conn_pkg::op_syn_ack;
        hdr_sts = tcp_conn_pkg::tcp_connecting;
      end
      tcp_conn_pkg::send_ack_s:      hdr_sts = tcp_conn_pkg::tcp_connecting;
      tcp_conn_pkg::send_fin_s:      hdr_op  = tcp_conn_pkg::op_fin_ack;
      tcp_conn_pkg::send_last_ack_s: hdr_ack = loc_ack + 32'd1; // acks the peer's fin
      tcp_conn_pkg::send_rst_s:      hdr_op  = tcp_conn_pkg::op_rst_ack;
      default:                       is_send = 1'b0;
    endcase
  end

  always_comb begin
    case (tx_op)
      tcp_conn_pkg::op_syn:     tx_flags = tcp_hdr_pkg::TCP_FLAG_SYN;
      tcp_conn_pkg::op_syn_ack: tx_flags = tcp_hdr_pkg::tcp_flags_t'(
                                  tcp_hdr_pkg::TCP_FLAG_SYN | tcp_hdr_pkg::TCP_FLAG_ACK);
      tcp_conn_pkg::op_fin_ack: tx_flags = tcp_hdr_pkg::tcp_flags_t'(
                                  tcp_hdr_pkg::TCP_FLAG_FIN | tcp_hdr_pkg::TCP_FLAG_ACK);
      tcp_conn_pkg::op_rst_ack: tx_flags = tcp_hdr_pkg::tcp_flags_t'(
                                  tcp_hdr_pkg::TCP_FLAG_RST | tcp_hdr_pkg::TCP_FLAG_ACK);
      default:                  tx_flags = tcp_hdr_pkg::TCP_FLAG_ACK;
    endcase
  end

  // header held while the send state waits for tx_acc
  always_ff @(posedge clk) begin
    if (is_send) begin
      tx_op  <= hdr_op;
      tx_seq <= loc_seq;
      tx_ack <= hdr_ack;
    end
  end

  //////////////////////////////////////////////////
  // connection state machine
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= tcp_conn_pkg::closed_s;
      close        <= tcp_conn_pkg::close_none;
      status       <= tcp_conn_pkg::tcp_closed;
      tmr_en       <= 1'b0;
      tx_rdy       <= 1'b0;
      is_server    <= 1'b0;
      fin_acked    <= 1'b0;
      con_loc_port <= '0;
      con_rem_port <= '0;
      con_ip       <= '0;
      con_port     <= '0;
    end else if (timeout) begin
      state  <= tcp_conn_pkg::closed_s; // connect or disconnect stalled
      tx_rdy <= 1'b0;
    end else begin
      if (is_send) begin
        status <= hdr_sts;
        tmr_en <= 1'b1;
        tx_rdy <= !tx_take;             // falls the cycle after acceptance
      end
      case (state)
        tcp_conn_pkg::closed_s: begin
          status    <= tcp_conn_pkg::tcp_closed;
          tmr_en    <= 1'b0;
          close     <= tcp_conn_pkg::close_none;
          fin_acked <= 1'b0;
          if (listen) begin
            is_server <= 1'b1;
            state     <= tcp_conn_pkg::listen_s;
          end else if (connect) begin
            is_server    <= 1'b0;
            con_loc_port <= loc_port;
            con_rem_port <= rem_port;
            rem_ip_q     <= rem_ip;
            loc_seq      <= ISN;
            loc_ack      <= '0;
            state        <= tcp_conn_pkg::send_syn_s;
          end
        end
        tcp_conn_pkg::listen_s: begin
          status <= tcp_conn_pkg::tcp_listening;
          if (!listen) begin
            state <= tcp_conn_pkg::closed_s;
          end else if (seg.syn_rec) begin
            con_loc_port <= loc_port;
            con_rem_port <= seg.seg_src_port;
            rem_ip_q     <= seg.seg_src_ip;
            loc_seq      <= ISN;
            loc_ack      <= seg.seg_seq + 32'd1;
            state        <= tcp_conn_pkg::send_syn_ack_s;
          end
        end
        tcp_conn_pkg::send_syn_s: if (tx_take) state <= tcp_conn_pkg::syn_sent_s;
        tcp_conn_pkg::syn_sent_s: begin
          if (seg.syn_ack_rec) begin
            loc_seq <= ISN + 32'd1;
            loc_ack <= seg.seg_seq + 32'd1;
            state   <= tcp_conn_pkg::send_ack_s;
          end
        end
        tcp_conn_pkg::send_ack_s: if (tx_take) state <= tcp_conn_pkg::ack_sent_s;
        tcp_conn_pkg::ack_sent_s: if (tx_done) state <= tcp_conn_pkg::established_s;
        tcp_conn_pkg::send_syn_ack_s: if (tx_take) state <= tcp_conn_pkg::syn_ack_sent_s;
        tcp_conn_pkg::syn_ack_sent_s: begin
          // handshake ack must follow the peer's syn and cover ours
          if (seg.ack_rec && (seg.seg_seq == loc_ack) && (seg.seg_ack == ISN + 32'd1)) begin
            loc_seq <= ISN + 32'd1;
            state   <= tcp_conn_pkg::established_s;
          end
        end
        tcp_conn_pkg::established_s: begin
          status   <= tcp_conn_pkg::tcp_connected;
          tmr_en   <= 1'b0;
          con_ip   <= rem_ip_q;
          con_port <= con_rem_port;
          case (close)
            tcp_conn_pkg::close_active:  state <= tcp_conn_pkg::send_fin_s;
            tcp_conn_pkg::close_passive: state <= tcp_conn_pkg::send_last_ack_s;
            tcp_conn_pkg::close_reset:   state <= tcp_conn_pkg::send_rst_s;
            default: begin
              if (usr_dcn) close <= tcp_conn_pkg::close_active;
              else if (seg.fin_rec) close <= tcp_conn_pkg::close_passive;
              else if (seg.rst_rec) close <= tcp_conn_pkg::close_reset;
            end
          endcase
        end
        tcp_conn_pkg::send_fin_s: if (tx_take) state <= tcp_conn_pkg::fin_sent_s;
        tcp_conn_pkg::fin_sent_s: begin
          if (close == tcp_conn_pkg::close_passive) begin
            if (seg.ack_rec) state <= tcp_conn_pkg::closed_s; // last ack from peer
          end else begin
            if (seg.ack_rec) fin_acked <= 1'b1;
            if (fin_acked && seg.fin_rec) state <= tcp_conn_pkg::send_last_ack_s;
          end
        end
        tcp_conn_pkg::send_last_ack_s: begin
          if (tx_take) begin
            loc_ack <= loc_ack + 32'd1;
            state   <= tcp_conn_pkg::last_ack_sent_s;
          end
        end
        tcp_conn_pkg::last_ack_sent_s: begin
          if (tx_done) begin
            state <= (close == tcp_conn_pkg::close_passive) ? tcp_conn_pkg::send_fin_s
                                                            : tcp_conn_pkg::closed_s;
          end
        end
        tcp_conn_pkg::send_rst_s: if (tx_take) state <= tcp_conn_pkg::closed_s;
        default: state <= tcp_conn_pkg::closed_s;
      endcase
    end
  end

  a_hdr_hold: assert property (@(posedge clk) disable iff (rst)
    is_send && tx_rdy && !tx_acc
      |=> $stable({tx_op, tx_seq, tx_ack, tx_dst_ip, tx_src_port, tx_dst_port}))
    else $error("transmit header changed before acceptance");

  a_tmr_pending: assert property (@(posedge clk) disable iff (rst)
    tmr_en |-> status inside {tcp_conn_pkg::tcp_connecting, tcp_conn_pkg::tcp_disconnecting})
    else $error("timer running outside connect or disconnect");

endmodule : tcp_conn_fsm

`default_nettype wire

//--- hdl/tcp_conn_pkg.sv
`default_nettype none

package tcp_conn_pkg;

  // connection state machine
  typedef enum logic [3:0] {
    closed_s,
    listen_s,
    send_syn_s,
    syn_sent_s,
    send_ack_s,
    ack_sent_s,
    send_syn_ack_s,
    syn_ack_sent_s,
    established_s,
    send_fin_s,
    fin_sent_s,
    send_last_ack_s,
    last_ack_sent_s,
    send_rst_s
  } conn_state_t;

  typedef enum logic [1:0] {
    close_none,
    close_active,    // local user dropped its request
    close_passive,   // peer sent fin
    close_reset      // peer sent rst
  } close_t;

  typedef enum logic [2:0] {
    tcp_closed,
    tcp_listening,
    tcp_connecting,
    tcp_connected,
    tcp_disconnecting
  } conn_status_t;

  // control segment kinds, selects the flag byte
  typedef enum logic [2:0] {
    op_syn,
    op_syn_ack,
    op_ack,
    op_fin_ack,
    op_rst_ack
  } seg_op_t;

endpackage : tcp_conn_pkg

`default_nettype wire

//--- hdl/tcp_conn_timer.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_conn_timer #(
  parameter int CONNECTION_TIMEOUT = 10000
) (
  input  logic clk,
  input  logic rst,
  input  logic en,
  output logic timeout
);

  // one extra count past terminal so the pulse fires once
  localparam int CNT_W = $clog2(CONNECTION_TIMEOUT + 2);

  logic [CNT_W-1:0] cnt;

  always_ff @(posedge clk) begin
    if (rst || !en) begin
      cnt <= '0;                               // idle or cleared by fsm
    end else if (cnt <= CNT_W'(CONNECTION_TIMEOUT)) begin
      cnt <= cnt + CNT_W'(1);
    end
  end

  assign timeout = en && (cnt == CNT_W'(CONNECTION_TIMEOUT));

  a_tmo_single: assert property (@(posedge clk) disable iff (rst)
    timeout |=> !timeout)
    else $error("timeout pulse lasted more than one cycle");

endmodule : tcp_conn_timer

`default_nettype wire

//--- hdl/tcp_hdr_pkg.sv
`default_nettype none

package tcp_hdr_pkg;

  typedef logic [15:0] tcp_port_t;   // tcp port number
  typedef logic [31:0] tcp_num_t;    // sequence or acknowledgment number
  typedef logic [31:0] ipv4_addr_t;
  typedef logic [15:0] tcp_wnd_t;    // advertised window

  // flag byte in wire order, cwr sits in the msb
  typedef struct packed {
    logic cwr;
    logic ece;
    logic urg;
    logic ack;
    logic psh;
    logic rst;
    logic syn;
    logic fin;
  } tcp_flags_t;

  localparam tcp_flags_t TCP_FLAG_FIN = 8'h01;
  localparam tcp_flags_t TCP_FLAG_SYN = 8'h02;
  localparam tcp_flags_t TCP_FLAG_RST = 8'h04;
  localparam tcp_flags_t TCP_FLAG_ACK = 8'h10;

endpackage : tcp_hdr_pkg

`default_nettype wire

//--- hdl/tcp_seg_classifier.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_seg_classifier (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    rx_val,
  input  tcp_hdr_pkg::ipv4_addr_t rx_src_ip,
  input  tcp_hdr_pkg::tcp_port_t  rx_src_port,
  input  tcp_hdr_pkg::tcp_port_t  rx_dst_port,
  input  tcp_hdr_pkg::tcp_flags_t rx_flags,
  input  tcp_hdr_pkg::tcp_num_t   rx_seq,
  input  tcp_hdr_pkg::tcp_num_t   rx_ack,
  input  tcp_hdr_pkg::tcp_port_t  loc_port,
  input  tcp_hdr_pkg::tcp_port_t  con_loc_port,
  input  tcp_hdr_pkg::tcp_port_t  con_rem_port,
  tcp_seg_ifc.classifier          seg
);

  logic loc_hit;   // addressed to the user's open port
  logic con_hit;   // belongs to the current connection

  assign loc_hit = rx_val && (rx_dst_port == loc_port);
  assign con_hit = rx_val && (rx_src_port == con_rem_port) && (rx_dst_port == con_loc_port);

  always_ff @(posedge clk) begin
    if (rst) begin
      seg.syn_rec     <= 1'b0;
      seg.syn_ack_rec <= 1'b0;
      seg.ack_rec     <= 1'b0;
      seg.fin_rec     <= 1'b0;
      seg.rst_rec     <= 1'b0;
    end else begin
      seg.syn_rec     <= loc_hit && rx_flags.syn && !rx_flags.ack;
      seg.syn_ack_rec <= loc_hit && rx_flags.syn && rx_flags.ack;
      seg.ack_rec     <= con_hit && rx_flags.ack && !rx_flags.syn; // plain or fin ack
      seg.fin_rec     <= con_hit && rx_flags.fin;
      seg.rst_rec     <= con_hit && rx_flags.rst;
    end
  end

  // fields line up with the event pulses of the same segment
  always_ff @(posedge clk) begin
    if (rx_val) begin
      seg.seg_seq      <= rx_seq;
      seg.seg_ack      <= rx_ack;
      seg.seg_src_port <= rx_src_port;
      seg.seg_src_ip   <= rx_src_ip;
    end
  end

endmodule : tcp_seg_classifier

`default_nettype wire

//--- hdl/tcp_seg_ifc.sv
`timescale 1ns/1ps
`default_nettype none

interface tcp_seg_ifc;

  logic                    syn_rec;       // syn to local port, no ack
  logic                    syn_ack_rec;   // syn with ack to local port
  logic                    ack_rec;       // ack on connection ports
  logic                    fin_rec;
  logic                    rst_rec;
  tcp_hdr_pkg::tcp_num_t   seg_seq;       // fields of the last valid segment
  tcp_hdr_pkg::tcp_num_t   seg_ack;
  tcp_hdr_pkg::tcp_port_t  seg_src_port;
  tcp_hdr_pkg::ipv4_addr_t seg_src_ip;

  modport classifier (
    output syn_rec, syn_ack_rec, ack_rec, fin_rec, rst_rec,
    output seg_seq, seg_ack, seg_src_port, seg_src_ip
  );

  modport fsm (
    input syn_rec, syn_ack_rec, ack_rec, fin_rec, rst_rec,
    input seg_seq, seg_ack, seg_src_port, seg_src_ip
  );

endinterface : tcp_seg_ifc

`default_nettype wire

//--- list.f
hdl/tcp_hdr_pkg.sv
hdl/tcp_conn_pkg.sv
hdl/tcp_seg_ifc.sv
hdl/tcp_seg_classifier.sv
hdl/tcp_conn_timer.sv
hdl/tcp_conn_fsm.sv
hdl/tcp_conn_engine.sv
test/tb_tcp_conn_engine.sv

//--- test/tb_tcp_conn_engine.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tcp_conn_engine;

  localparam int TMO      = 200;
  localparam int WND      = 4000;
  localparam int ISN      = 2000;
  localparam int WAIT_MAX = TMO + 100;   // longest wait for a single event
  localparam int N_TESTS  = 6;
  localparam int TEST_CYC = 2000;

  localparam logic [15:0] CLI_PORT  = 16'd5001;
  localparam logic [15:0] REM_PORT  = 16'd80;
  localparam logic [31:0] REM_IP    = 32'h0a00_0002;
  localparam logic [15:0] SRV_PORT  = 16'd8080;
  localparam logic [15:0] PEER_PORT = 16'd40123;
  localparam logic [31:0] PEER_IP   = 32'hc0a8_0105;

  logic                       clk;
  logic                       rst;
  logic                       connect;
  logic                       listen;
  tcp_hdr_pkg::tcp_port_t     loc_port;
  tcp_hdr_pkg::tcp_port_t     rem_port;
  tcp_hdr_pkg::ipv4_addr_t    rem_ip;
  logic                       rx_val;
  tcp_hdr_pkg::ipv4_addr_t    rx_src_ip;
  tcp_hdr_pkg::tcp_port_t     rx_src_port;
  tcp_hdr_pkg::tcp_port_t     rx_dst_port;
  tcp_hdr_pkg::tcp_flags_t    rx_flags;
  tcp_hdr_pkg::tcp_num_t      rx_seq;
  tcp_hdr_pkg::tcp_num_t      rx_ack;
  logic                       tx_acc;
  logic                       tx_done;
  logic                       tx_rdy;
  tcp_conn_pkg::seg_op_t      tx_op;
  tcp_hdr_pkg::tcp_flags_t    tx_flags;
  tcp_hdr_pkg::ipv4_addr_t    tx_dst_ip;
  tcp_hdr_pkg::tcp_port_t     tx_src_port;
  tcp_hdr_pkg::tcp_port_t     tx_dst_port;
  tcp_hdr_pkg::tcp_num_t      tx_seq;
  tcp_hdr_pkg::tcp_num_t      tx_ack;
  tcp_hdr_pkg::tcp_wnd_t      tx_wnd;
  tcp_conn_pkg::conn_status_t status;
  tcp_hdr_pkg::ipv4_addr_t    con_ip;
  tcp_hdr_pkg::tcp_port_t     con_port;

  tcp_conn_pkg::seg_op_t exp_op;      // next header the peer should see
  logic [31:0]           exp_seq;
  logic [31:0]           exp_ack;
  logic [31:0]           exp_ip;
  logic [15:0]           exp_sport;
  logic [15:0]           exp_dport;
  logic                  accept;
  logic                  peer_hold;   // peer withholds tx_acc
  logic                  tmo_armed;   // tx_rdy may fall on timeout
  int                    cyc = 0;
  int                    err_cnt = 0;
  int                    err_mark = 0;
  int                    test_cnt = 0;
  int                    fail_cnt = 0;

  tcp_conn_engine #(
    .CONNECTION_TIMEOUT  (TMO),
    .DEFAULT_WINDOW_SIZE (WND),
    .ISN                 (32'(ISN))
  ) dut_i (.*);

  initial clk = 1'b0;
  always #20 clk = ~clk;
  always @(posedge clk) cyc <= cyc + 1;

  assign accept = tx_rdy && tx_acc;

  function automatic void report_mismatch(input string name, input logic [31:0] got,
                                          input logic [31:0] exp);
    err_cnt++;
    $display("FAIL %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
  endfunction

  function automatic void report_fault(input string msg);
    err_cnt++;
    $display("ERROR %s at %0t", msg, $time);
  endfunction

  // flag byte of each control segment in wire order
  function automatic logic [7:0] flags_of(input tcp_conn_pkg::seg_op_t op);
    case (op)
      tcp_conn_pkg::op_syn:     return 8'h02;
      tcp_conn_pkg::op_syn_ack: return 8'h12;
      tcp_conn_pkg::op_fin_ack: return 8'h11;
      tcp_conn_pkg::op_rst_ack: return 8'h14;
      default:                  return 8'h10;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // header checks on every accepted segment
  //////////////////////////////////////////////////
  a_op: assert property (@(posedge clk) disable iff (rst) accept |-> tx_op == exp_op)
    else report_mismatch("tx_op", 32'($sampled(tx_op)), 32'(exp_op));
  a_flags: assert property (@(posedge clk) disable iff (rst)
    accept |-> tx_flags == flags_of(exp_op))
    else report_mismatch("tx_flags", 32'($sampled(tx_flags)), 32'(flags_of(exp_op)));
  a_seq: assert property (@(posedge clk) disable iff (rst) accept |-> tx_seq == exp_seq)
    else report_mismatch("tx_seq", $sampled(tx_seq), exp_seq);
  a_ack: assert property (@(posedge clk) disable iff (rst) accept |-> tx_ack == exp_ack)
    else report_mismatch("tx_ack", $sampled(tx_ack), exp_ack);
  a_wnd: assert property (@(posedge clk) disable iff (rst) accept |-> tx_wnd == 16'(WND))
    else report_mismatch("tx_wnd", 32'($sampled(tx_wnd)), 32'(WND));
  a_dst_ip: assert property (@(posedge clk) disable iff (rst) accept |-> tx_dst_ip == exp_ip)
    else report_mismatch("tx_dst_ip", $sampled(tx_dst_ip), exp_ip);
  a_sport: assert property (@(posedge clk) disable iff (rst)
    accept |-> tx_src_port == exp_sport)
    else report_mismatch("tx_src_port", 32'($sampled(tx_src_port)), 32'(exp_sport));
  a_dport: assert property (@(posedge clk) disable iff (rst)
    accept |-> tx_dst_port == exp_dport)
    else report_mismatch("tx_dst_port", 32'($sampled(tx_dst_port)), 32'(exp_dport));

  // back-pressure keeps the header and tx_rdy in place
  a_hold: assert property (@(posedge clk) disable iff (rst)
    tx_rdy && !tx_acc |=> $stable({tx_op, tx_flags, tx_seq, tx_ack, tx_wnd, tx_dst_ip,
                                    tx_src_port, tx_dst_port}))
    else report_fault("transmit header changed while tx_acc was low");
  a_rdy_drop: assert property (@(posedge clk) disable iff (rst)
    $fell(tx_rdy) |-> $past(tx_acc) || tmo_armed)
    else report_fault("tx_rdy fell without acceptance or timeout");

  // peer: accepts after 0 to 3 cycles, tx_done two cycles later
  always begin : peer_model
    int unsigned dly;
    @(negedge clk);
    if (tx_rdy && !peer_hold) begin
      dly = $urandom_range(3, 0);
      repeat (dly) @(negedge clk);
      tx_acc = 1'b1;
      @(negedge clk);
      tx_acc = 1'b0;
      @(negedge clk);
      tx_done = 1'b1;
      @(negedge clk);
      tx_done = 1'b0;
    end
  end

  initial begin : watchdog
    repeat (N_TESTS * TEST_CYC) @(posedge clk);
    $display("watchdog expired after %0d cycles", N_TESTS * TEST_CYC);
    $display("Simulation finished: FAIL");
    $finish;
  end

  //////////////////////////////////////////////////
  // stimulus helpers, all start and end on a falling edge
  //////////////////////////////////////////////////
  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp) else report_mismatch(name, got, exp);
  endtask

  task automatic set_seg(input tcp_conn_pkg::seg_op_t op, input logic [31:0] seq,
                         input logic [31:0] ack);
    exp_op  = op;
    exp_seq = seq;
    exp_ack = ack;
  endtask

  task automatic set_peer(input logic [31:0] ip, input logic [15:0] sport,
                          input logic [15:0] dport);
    exp_ip    = ip;
    exp_sport = sport;   // our port, seen as source in tx
    exp_dport = dport;
  endtask

  task automatic send_seg(input logic [31:0] ip, input logic [15:0] sport,
                          input logic [15:0] dport, input logic [7:0] flags,
                          input logic [31:0] seq, input logic [31:0] ack);
    rx_src_ip   = ip;
    rx_src_port = sport;
    rx_dst_port = dport;
    rx_flags    = tcp_hdr_pkg::tcp_flags_t'(flags);
    rx_seq      = seq;
    rx_ack      = ack;
    rx_val      = 1'b1;
    @(negedge clk);
    rx_val      = 1'b0;
  endtask

  task automatic wait_accept(input string what);
    int  n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < WAIT_MAX) begin
      @(posedge clk);
      seen = tx_rdy && tx_acc;     // pre-edge values
      n++;
    end
    if (!seen) report_fault({what, " segment was never accepted"});
    @(negedge clk);
  endtask

  task automatic wait_rdy(input string what);
    int n;
    n = 0;
    while (!tx_rdy && n < WAIT_MAX) begin
      @(negedge clk);
      n++;
    end
    if (!tx_rdy) report_fault({what, " segment was never offered"});
  endtask

  task automatic wait_status(input tcp_conn_pkg::conn_status_t sts, input string what);
    int n;
    n = 0;
    while (status != sts && n < WAIT_MAX) begin
      @(negedge clk);
      n++;
    end
    if (status != sts) report_fault({"status never became ", what});
  endtask

  task automatic open_client(input logic [31:0] p);
    loc_port = CLI_PORT;
    rem_port = REM_PORT;
    rem_ip   = REM_IP;
    set_peer(REM_IP, CLI_PORT, REM_PORT);
    set_seg(tcp_conn_pkg::op_syn, 32'(ISN), 32'd0);
    connect = 1'b1;
    wait_accept("syn");
    set_seg(tcp_conn_pkg::op_ack, 32'(ISN + 1), p + 32'd1);
    send_seg(REM_IP, REM_PORT, CLI_PORT, 8'h12, p, 32'(ISN + 1));
    wait_accept("handshake ack");
    wait_status(tcp_conn_pkg::tcp_connected, "connected");
    check_eq("con_port", 32'(con_port), 32'(REM_PORT));
    check_eq("con_ip", con_ip, REM_IP);
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    if (err_cnt == err_mark) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      fail_cnt++;
      $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - err_mark);
    end
    err_mark = err_cnt;
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////
  initial begin : main
    logic [31:0] p;
    int          t0;
    rst = 1'b1;
    connect = 1'b0;
    listen = 1'b0;
    loc_port = '0;
    rem_port = '0;
    rem_ip = '0;
    rx_val = 1'b0;
    rx_src_ip = '0;
    rx_src_port = '0;
    rx_dst_port = '0;
    rx_flags = '0;
    rx_seq = '0;
    rx_ack = '0;
    tx_acc = 1'b0;
    tx_done = 1'b0;
    peer_hold = 1'b0;
    tmo_armed = 1'b0;
    set_seg(tcp_conn_pkg::op_syn, '0, '0);
    set_peer('0, '0, '0);
    void'($urandom(67));
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // active open, after a check of the reset values
    check_eq("tx_rdy", 32'(tx_rdy), 32'd0);
    check_eq("status", 32'(status), 32'(tcp_conn_pkg::tcp_closed));
    check_eq("con_port", 32'(con_port), 32'd0);
    check_eq("con_ip", con_ip, 32'd0);
    p = $urandom;
    open_client(p);
    end_test("active open");

    // active close of the client
    set_seg(tcp_conn_pkg::op_fin_ack, 32'(ISN + 1), p + 32'd1);
    connect = 1'b0;
    wait_accept("fin");
    send_seg(REM_IP, REM_PORT, CLI_PORT, 8'h10, p + 32'd1, 32'(ISN + 2));
    set_seg(tcp_conn_pkg::op_ack, 32'(ISN + 1), p + 32'd2);
    send_seg(REM_IP, REM_PORT, CLI_PORT, 8'h11, p + 32'd1, 32'(ISN + 2));
    wait_accept("last ack");
    wait_status(tcp_conn_pkg::tcp_closed, "closed");
    end_test("active close");

    // passive open, first syn goes to the wrong port
    loc_port = SRV_PORT;
    listen   = 1'b1;
    wait_status(tcp_conn_pkg::tcp_listening, "listening");
    send_seg(PEER_IP, PEER_PORT, SRV_PORT + 16'd1, 8'h02, 32'h1111_0000, 32'd0);
    repeat (8) @(negedge clk);
    check_eq("status", 32'(status), 32'(tcp_conn_pkg::tcp_listening));
    check_eq("tx_rdy", 32'(tx_rdy), 32'd0);
    p = $urandom;
    set_peer(PEER_IP, SRV_PORT, PEER_PORT);
    set_seg(tcp_conn_pkg::op_syn_ack, 32'(ISN), p + 32'd1);
    send_seg(PEER_IP, PEER_PORT, SRV_PORT, 8'h02, p, 32'd0);
    wait_accept("syn-ack");
    send_seg(PEER_IP, PEER_PORT, SRV_PORT, 8'h10, p + 32'd1, 32'(ISN + 1));
    wait_status(tcp_conn_pkg::tcp_connected, "connected");
    end_test("passive open");

    // passive close, peer sends fin first
    set_seg(tcp_conn_pkg::op_ack, 32'(ISN + 1), p + 32'd2);
    send_seg(PEER_IP, PEER_PORT, SRV_PORT, 8'h11, p + 32'd1, 32'(ISN + 1));
    wait_accept("ack of peer fin");
    set_seg(tcp_conn_pkg::op_fin_ack, 32'(ISN + 1), p + 32'd2);
    wait_accept("fin");
    listen = 1'b0;                  // stay closed afterwards
    send_seg(PEER_IP, PEER_PORT, SRV_PORT, 8'h10, p + 32'd2, 32'(ISN + 2));
    wait_status(tcp_conn_pkg::tcp_closed, "closed");
    end_test("passive close");

    // reset from the peer
    p = $urandom;
    open_client(p);
    send_seg(REM_IP, REM_PORT + 16'd1, CLI_PORT, 8'h04, p + 32'd1, 32'(ISN + 1));
    repeat (8) @(negedge clk);
    check_eq("status", 32'(status), 32'(tcp_conn_pkg::tcp_connected));
    check_eq("tx_rdy", 32'(tx_rdy), 32'd0);
    set_seg(tcp_conn_pkg::op_rst_ack, 32'(ISN + 1), p + 32'd1);
    send_seg(REM_IP, REM_PORT, CLI_PORT, 8'h04, p + 32'd1, 32'(ISN + 1));
    wait_rdy("rst-ack");
    connect = 1'b0;                 // close reason already latched
    wait_accept("rst-ack");
    wait_status(tcp_conn_pkg::tcp_closed, "closed");
    end_test("reset");

    // timeout with back-pressure, ports left from the previous client
    peer_hold = 1'b1;               // peer stays silent, syn is never taken
    connect = 1'b1;
    wait_status(tcp_conn_pkg::tcp_connecting, "connecting");
    t0 = cyc;
    connect = 1'b0;
    repeat (20) @(negedge clk);
    check_eq("tx_rdy", 32'(tx_rdy), 32'd1);
    tmo_armed = 1'b1;
    wait_status(tcp_conn_pkg::tcp_closed, "closed after timeout");
    assert (cyc - t0 >= TMO && cyc - t0 <= TMO + 8)
      else report_fault($sformatf("timeout took %0d cycles", cyc - t0));
    check_eq("tx_rdy", 32'(tx_rdy), 32'd0);
    end_test("timeout and back-pressure");

    $display("tests run %0d, tests failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule : tb_tcp_conn_engine

`default_nettype wire
